// ==== alu/int_alu.sv ====
/*
 * Integer ALU
 * Single-cycle add, sub, logic, compare and shift on a decoded micro-op,
 * with sign extension of word results
 */
`timescale 1ns/100ps
`include "int_unit_consts.svh"

module int_alu (
    input  int_unit_pkg::int_uop_t  uop_i,
    output int_unit_pkg::data_t     result_o
);
    import int_unit_pkg::*;

    data_t res;
    data_t sra_src;
    logic  lt_s, lt_u;

    // word sra shifts in bit 31, not bit 63
    assign sra_src = uop_i.word ? {{(`XLEN-32){uop_i.opa[31]}}, uop_i.opa[31:0]} : uop_i.opa;

    assign lt_s = $signed(uop_i.opa) < $signed(uop_i.opb);
    assign lt_u = uop_i.opa < uop_i.opb;

    always_comb begin
        case (uop_i.op)
            ALU_ADD:    res = uop_i.opa + uop_i.opb;
            ALU_SUB:    res = uop_i.opa - uop_i.opb;
            ALU_SLL:    res = uop_i.opa << uop_i.shamt;
            ALU_SLT:    res = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   res = {{(`XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    res = uop_i.opa ^ uop_i.opb;
            ALU_SRL:    res = uop_i.opa >> uop_i.shamt;
            ALU_SRA:    res = $signed(sra_src) >>> uop_i.shamt;
            ALU_OR:     res = uop_i.opa | uop_i.opb;
            ALU_AND:    res = uop_i.opa & uop_i.opb;
            ALU_PASS_B: res = uop_i.opb;
            default:    res = '0;
        endcase
    end

    // ------------------------------
    // result formatting
    // ------------------------------
    always_comb begin
        if (uop_i.illegal)
            result_o = '0;
        else if (uop_i.word)
            result_o = {{(`XLEN-32){res[31]}}, res[31:0]};
        else
            result_o = res;
    end

endmodule

// ==== alu/int_decoder.sv ====
/*
 * Integer decoder
 * Splits an RV64I instruction into a micro-op, forms operands and
 * immediates, builds lui/auipc values and flags illegal encodings
 */
`timescale 1ns/100ps
`include "int_unit_consts.svh"

module int_decoder (
    input  logic [31:0]             inst_i,
    input  logic [`PC_W-1:0]        pc_i,
    input  int_unit_pkg::data_t     rs1_data_i,
    input  int_unit_pkg::data_t     rs2_data_i,
    output int_unit_pkg::int_uop_t  uop_o
);
    import int_unit_pkg::*;

    logic [6:0] opcode, funct7;
    logic [2:0] funct3;
    logic       word, word_f3, shift;
    data_t      src1, src2, imm_i, imm_u;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign word    = (opcode == `OPC_OP_32) || (opcode == `OPC_OP_IMM_32);
    assign word_f3 = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);
    assign shift   = (funct3[1:0] == 2'b01);

    // word forms only look at the low half of the sources
    assign src1  = word ? {32'h0, rs1_data_i[31:0]} : rs1_data_i;
    assign src2  = word ? {32'h0, rs2_data_i[31:0]} : rs2_data_i;
    assign imm_i = word ? {32'h0, {20{inst_i[31]}}, inst_i[31:20]}
                        : {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {{(`XLEN-32){inst_i[31]}}, inst_i[31:12], 12'h0};

    always_comb begin
        uop_o         = '0;
        uop_o.op      = alu_op_e'({1'b0, funct3});
        uop_o.word    = word;
        uop_o.opa     = src1;
        uop_o.opb     = src2;
        uop_o.shamt   = word ? {1'b0, rs2_data_i[4:0]} : rs2_data_i[`SHAMT_W-1:0];
        uop_o.rd      = inst_i[11:7];
        case (opcode)
            `OPC_OP, `OPC_OP_32: begin
                case (funct7)
                    `F7_BASE:   uop_o.illegal = word & ~word_f3;  // no sltw, xorw ...
                    `F7_ALT: begin
                        uop_o.op      = (funct3 == 3'b000) ? ALU_SUB : ALU_SRA;
                        uop_o.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                    end
                    `F7_MULDIV: begin  // only the 64-bit div/rem group remains
                        uop_o.is_div     = ~word & funct3[2];
                        uop_o.div_signed = ~funct3[0];
                        uop_o.div_rem    = funct3[1];
                        uop_o.illegal    = word | ~funct3[2];
                    end
                    default:    uop_o.illegal = 1'b1;
                endcase
            end
            `OPC_OP_IMM, `OPC_OP_IMM_32: begin
                uop_o.opb     = imm_i;
                uop_o.shamt   = inst_i[25:20];
                uop_o.illegal = word & ~word_f3;
                if (funct3 == 3'b101 && funct7[6:1] == 6'b010000)
                    uop_o.op = ALU_SRA;
                else if (shift && funct7[6:1] != 6'b000000)
                    uop_o.illegal = 1'b1;
                if (shift && word && inst_i[25])  // shamt[5] set on a word shift
                    uop_o.illegal = 1'b1;
            end
            `OPC_LUI: begin
                uop_o.op  = ALU_PASS_B;
                uop_o.opb = imm_u;
            end
            `OPC_AUIPC: begin
                uop_o.op  = ALU_PASS_B;
                uop_o.opb = imm_u + {{(`XLEN-`PC_W){pc_i[`PC_W-1]}}, pc_i};
            end
            default:    uop_o.illegal = 1'b1;
        endcase
    end

endmodule

// ==== common/div_ctrl_if.sv ====
/*
 * Divider control interface
 * Load, step and finish strobes from the divider FSM to its data path
 */
`timescale 1ns/100ps

interface div_ctrl_if;

    logic load;    // capture magnitudes and special cases
    logic step;    // one restoring-division iteration
    logic finish;  // corrected result is valid

    modport ctrl (
        output load, step, finish
    );

    modport dp (
        input load, step, finish
    );

endinterface

// ==== common/int_unit_consts.svh ====
/*
 * Integer unit constants
 * Data and field widths, RV64I major opcodes and funct7 values
 */
`ifndef INT_UNIT_CONSTS_SVH
`define INT_UNIT_CONSTS_SVH

`define XLEN          64
`define SHAMT_W       6
`define REG_ADDR_W    5
`define PC_W          40

`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP_32     7'b0111011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111

`define F7_BASE       7'b0000000
`define F7_ALT        7'b0100000
`define F7_MULDIV     7'b0000001

`endif

// ==== common/int_unit_pkg.sv ====
/*
 * Integer unit types
 * Data word, ALU operation codes and the decoded micro-op
 */
`include "int_unit_consts.svh"

package int_unit_pkg;

    typedef logic [`XLEN-1:0] data_t;

    // low eight codes follow funct3 of the base encodings
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SLL    = 4'd1,
        ALU_SLT    = 4'd2,
        ALU_SLTU   = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SRL    = 4'd5,
        ALU_OR     = 4'd6,
        ALU_AND    = 4'd7,
        ALU_SUB    = 4'd8,
        ALU_SRA    = 4'd9,
        ALU_PASS_B = 4'd10  // lui / auipc, value formed by the decoder
    } alu_op_e;

    typedef struct packed {
        alu_op_e                op;
        logic                   word;        // 32-bit form, result sign-extended
        data_t                  opa;
        data_t                  opb;
        logic [`SHAMT_W-1:0]    shamt;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   is_div;
        logic                   div_signed;
        logic                   div_rem;     // remainder instead of quotient
        logic                   illegal;
    } int_uop_t;

endpackage

// ==== div/div_ctrl.sv ====
/*
 * Divider FSM
 * Idle, load, run and done sequencing of the divider, abort on kill
 */
`timescale 1ns/100ps

module div_ctrl (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    start_i,
    input  logic    kill_i,
    input  logic    last_i,
    output logic    cnt_clr_o,
    output logic    cnt_en_o,
    output logic    busy_o,
    div_ctrl_if.ctrl ctl
);

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_RUN, S_DONE} state_e;

    state_e state_q, state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: if (start_i) state_d = S_LOAD;
            S_LOAD: state_d = S_RUN;
            S_RUN:  if (last_i) state_d = S_DONE;
            default: state_d = S_IDLE;
        endcase
        // exception at write-back flushes the divide in flight
        if (kill_i && state_q != S_IDLE)
            state_d = S_IDLE;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign ctl.load   = (state_q == S_LOAD);
    assign ctl.step   = (state_q == S_RUN);
    assign ctl.finish = (state_q == S_DONE);
    assign cnt_clr_o  = (state_q == S_LOAD);  // counter starts fresh each divide
    assign cnt_en_o   = (state_q == S_RUN);
    assign busy_o     = (state_q != S_IDLE);

endmodule

// ==== div/div_datapath.sv ====
/*
 * Divider data path
 * Restoring division on operand magnitudes, RISC-V divide-by-zero and
 * overflow results, and sign correction of quotient and remainder
 */
`timescale 1ns/100ps
`include "int_unit_consts.svh"

module div_datapath (
    input  logic                clk_i,
    input  logic                arst_n_i,
    div_ctrl_if.dp              ctl,
    input  logic                signed_i,
    input  logic                rem_i,
    input  int_unit_pkg::data_t dvnd_i,
    input  int_unit_pkg::data_t dvsr_i,
    output int_unit_pkg::data_t result_o
);
    import int_unit_pkg::*;

    localparam data_t MOST_NEG = {1'b1, {(`XLEN-1){1'b0}}};

    data_t            quo_q, rem_q, dvsr_q;
    data_t            dvnd_mag, dvsr_mag, quo_fix, rem_fix;
    logic [`XLEN:0]   rem_sh, diff;
    logic             neg_quo_q, neg_rem_q, by_zero_q, ovf_q;

    assign dvnd_mag = (signed_i && dvnd_i[`XLEN-1]) ? -dvnd_i : dvnd_i;
    assign dvsr_mag = (signed_i && dvsr_i[`XLEN-1]) ? -dvsr_i : dvsr_i;

    // shift next dividend bit into the partial remainder, then trial subtract
    assign rem_sh = {rem_q, quo_q[`XLEN-1]};
    assign diff   = rem_sh - {1'b0, dvsr_q};

    always_ff @(posedge clk_i) begin
        if (ctl.load) begin
            quo_q  <= dvnd_mag;
            rem_q  <= '0;
            dvsr_q <= dvsr_mag;
        end else if (ctl.step) begin
            quo_q <= {quo_q[`XLEN-2:0], ~diff[`XLEN]};
            rem_q <= diff[`XLEN] ? rem_sh[`XLEN-1:0] : diff[`XLEN-1:0];  // restore on borrow
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            neg_quo_q <= 1'b0;
            neg_rem_q <= 1'b0;
            by_zero_q <= 1'b0;
            ovf_q     <= 1'b0;
        end else if (ctl.load) begin
            neg_quo_q <= signed_i & (dvnd_i[`XLEN-1] ^ dvsr_i[`XLEN-1]);
            neg_rem_q <= signed_i & dvnd_i[`XLEN-1];  // remainder follows the dividend
            by_zero_q <= (dvsr_i == '0);
            ovf_q     <= signed_i && (dvnd_i == MOST_NEG) && (dvsr_i == '1);
        end
    end

    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    always_comb begin
        if (!ctl.finish)
            result_o = '0;
        else if (by_zero_q)
            result_o = rem_i ? dvnd_i : '1;
        else if (ovf_q)
            result_o = rem_i ? '0 : dvnd_i;
        else
            result_o = rem_i ? rem_fix : quo_fix;
    end

endmodule

// ==== div/div_step_counter.sv ====
/*
 * Divide step counter
 * Counts restoring-division iterations and flags the final one
 */
`timescale 1ns/100ps
`include "int_unit_consts.svh"

module div_step_counter #(
    parameter int unsigned STEPS = `XLEN
) (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic clr_i,
    input  logic en_i,
    output logic last_o
);

    localparam int unsigned CNT_W = $clog2(STEPS);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (clr_i) begin
            cnt_q <= '0;
        end else if (en_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign last_o = en_i && (cnt_q == CNT_W'(STEPS - 1));  // high during the last step

endmodule

// ==== dv/int_unit_tb.sv ====
/*
 * Integer unit testbench
 * Random and directed ALU, upper-immediate, illegal, divide and kill
 * traffic, checked against a reference model on every valid_o pulse
 */
`timescale 1ns/100ps
`include "int_unit_consts.svh"

module int_unit_tb;

    logic        clk = 1'b0;
    logic        arst_n, kill, valid_in, valid_out, illegal, busy;
    logic [39:0] pc;
    logic [31:0] inst;
    logic [63:0] rs1, rs2, result;
    logic [4:0]  rd_addr;
    logic [69:0] exp_q[$];  // {illegal, rd, result}
    integer      seed = 53899;
    integer      err_cnt = 0;
    integer      chk_cnt = 0;

    always #4 clk = ~clk;

    int_unit_top i_dut (.clk_i(clk), .arst_n_i(arst_n), .kill_i(kill), .valid_i(valid_in),
                        .pc_i(pc), .inst_i(inst), .rs1_data_i(rs1), .rs2_data_i(rs2),
                        .valid_o(valid_out), .result_o(result), .rd_addr_o(rd_addr),
                        .illegal_inst_o(illegal), .busy_o(busy));

    task automatic report_error(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        err_cnt = err_cnt + 1;
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    function automatic logic [63:0] div_ref(input logic [63:0] a, b, input logic sgn, rem);
        logic signed [63:0] sa, sb;
        sa = a;
        sb = b;
        if (b == 64'h0)
            return rem ? a : {64{1'b1}};
        if (sgn && a == {1'b1, 63'h0} && b == {64{1'b1}})
            return rem ? 64'h0 : a;
        if (sgn)
            return rem ? 64'(sa % sb) : 64'(sa / sb);
        return rem ? a % b : a / b;
    endfunction

    // returns {illegal, result}
    function automatic logic [64:0] ref_result(input logic [31:0] in, input logic [39:0] p,
                                               input logic [63:0] a, b);
        logic [6:0]  opc, f7;
        logic [2:0]  f3;
        logic [63:0] imm, r;
        logic [31:0] w;
        logic        ill;
        opc = in[6:0];
        f3  = in[14:12];
        f7  = in[31:25];
        imm = {{52{in[31]}}, in[31:20]};
        r   = 64'h0;
        w   = 32'h0;
        ill = 1'b0;
        case (opc)
            7'h33: begin
                if (f7 == 7'h00) begin
                    case (f3)
                        3'd0: r = a + b;
                        3'd1: r = a << b[5:0];
                        3'd2: r = {63'h0, $signed(a) < $signed(b)};
                        3'd3: r = {63'h0, a < b};
                        3'd4: r = a ^ b;
                        3'd5: r = a >> b[5:0];
                        3'd6: r = a | b;
                        default: r = a & b;
                    endcase
                end else if (f7 == 7'h20 && f3 == 3'd0) r = a - b;
                else if (f7 == 7'h20 && f3 == 3'd5) r = $signed(a) >>> b[5:0];
                else if (f7 == 7'h01 && f3[2]) r = div_ref(a, b, !f3[0], f3[1]);
                else ill = 1'b1;
            end
            7'h13: begin
                case (f3)
                    3'd0: r = a + imm;
                    3'd2: r = {63'h0, $signed(a) < $signed(imm)};
                    3'd3: r = {63'h0, a < imm};
                    3'd4: r = a ^ imm;
                    3'd6: r = a | imm;
                    3'd7: r = a & imm;
                    3'd1: begin
                        if (f7[6:1] == 6'h0)
                            r = a << in[25:20];
                        else
                            ill = 1'b1;
                    end
                    default: begin
                        if (f7[6:1] == 6'h0) r = a >> in[25:20];
                        else if (f7[6:1] == 6'b010000) r = $signed(a) >>> in[25:20];
                        else ill = 1'b1;
                    end
                endcase
            end
            7'h3b: begin
                if (f7 == 7'h00 && f3 == 3'd0) w = a[31:0] + b[31:0];
                else if (f7 == 7'h20 && f3 == 3'd0) w = a[31:0] - b[31:0];
                else if (f7 == 7'h00 && f3 == 3'd1) w = a[31:0] << b[4:0];
                else if (f7 == 7'h00 && f3 == 3'd5) w = a[31:0] >> b[4:0];
                else if (f7 == 7'h20 && f3 == 3'd5) w = $signed(a[31:0]) >>> b[4:0];
                else ill = 1'b1;
                r = {{32{w[31]}}, w};
            end
            7'h1b: begin
                if (f3 == 3'd0) w = a[31:0] + imm[31:0];
                else if (f3 == 3'd1 && f7 == 7'h00) w = a[31:0] << in[24:20];
                else if (f3 == 3'd5 && f7 == 7'h00) w = a[31:0] >> in[24:20];
                else if (f3 == 3'd5 && f7 == 7'h20) w = $signed(a[31:0]) >>> in[24:20];
                else ill = 1'b1;
                r = {{32{w[31]}}, w};
            end
            7'h37: r = {{32{in[31]}}, in[31:12], 12'h0};
            7'h17: r = {{32{in[31]}}, in[31:12], 12'h0} + {{24{p[39]}}, p};
            default: ill = 1'b1;
        endcase
        if (ill)
            r = 64'h0;
        return {ill, r};
    endfunction

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // comparing process, outputs are stable at the falling edge
    always @(negedge clk) begin
        logic [69:0] e;
        if (arst_n && valid_out) begin
            chk_cnt = chk_cnt + 1;
            if (exp_q.size() == 0) begin
                report_error("valid_o with no instruction pending");
            end else begin
                e = exp_q.pop_front();
                if (result !== e[63:0] || illegal !== e[69] || rd_addr !== e[68:64])
                    report_error($sformatf("got ill %0b rd %0d res %h, want %0b %0d %h",
                                 illegal, rd_addr, result, e[69], e[68:64], e[63:0]));
            end
        end
    end

    // offer one instruction for one cycle, expected result queued if it must be taken
    task automatic send(input logic [31:0] in, input logic [63:0] a, b, input logic take);
        logic [64:0] r;
        @(negedge clk);
        inst     = in;
        rs1      = a;
        rs2      = b;
        valid_in = 1'b1;
        r        = ref_result(in, pc, a, b);
        if (take)
            exp_q.push_back({r[64], in[11:7], r[63:0]});
        @(negedge clk);
        valid_in = 1'b0;
    endtask

    task automatic run_single(input logic [31:0] in, input logic [63:0] a, b);
        send(in, a, b, 1'b1);
        if (!valid_out)
            report_error("valid_o not one cycle after acceptance");
    endtask

    task automatic wait_div();
        integer i;
        for (i = 0; i < 200 && !valid_out; i = i + 1) begin
            if (!busy)
                report_error("busy_o low while divide pending");
            @(negedge clk);
        end
        if (!valid_out) begin
            $display("timeout waiting for divide result");
            err_cnt = err_cnt + 1;
            finish_run();
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done, checks %0d, errors %0d", name, chk_cnt, err_cnt);
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'($random(seed)), opc};
    endfunction

    initial begin
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [63:0] a, b;
        logic        alt;
        integer      n;
        arst_n = 1'b0;
        kill = 1'b0;
        valid_in = 1'b0;
        pc = 40'h0;
        inst = 32'h0;
        rs1 = 64'h0;
        rs2 = 64'h0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        if (valid_out || busy || result !== 64'h0)
            report_error("outputs not idle after reset");
        end_test("reset");

        // ------------------------------
        // ALU groups
        // ------------------------------
        for (n = 0; n < 200; n = n + 1) begin
            f3  = 3'($random(seed));
            alt = $random(seed);
            a   = rand64();
            b   = rand64();
            imm = 12'($random(seed));
            case (n % 4)
                0: run_single(r_type((alt && (f3 == 0 || f3 == 5)) ? 7'h20 : 7'h00, f3,
                                     7'h33), a, b);
                1: run_single(r_type((alt && f3 != 1) ? 7'h20 : 7'h00,
                                     (f3 > 5) ? 3'd5 : (f3 > 1) ? 3'd0 : f3, 7'h3b), a, b);
                2: begin
                    if (f3 == 1 || f3 == 5)
                        imm = {(alt && f3 == 5) ? 6'b010000 : 6'h0, imm[5:0]};
                    run_single({imm, 5'd1, f3, 5'($random(seed)), 7'h13}, a, b);
                end
                default: begin
                    if (f3 > 1)
                        f3 = 3'd5;
                    if (f3 != 0)
                        imm = {(alt && f3 == 5) ? 7'h20 : 7'h00, imm[4:0]};
                    run_single({imm, 5'd1, f3, 5'($random(seed)), 7'h1b}, a, b);
                end
            endcase
        end
        end_test("alu");

        for (n = 0; n < 40; n = n + 1) begin
            pc = {$random(seed), 8'($random(seed))};
            run_single({20'($random(seed)), 5'd3, (n % 2) ? 7'h37 : 7'h17}, rand64(), 0);
        end
        end_test("upper immediate");

        run_single({7'h01, 5'd9, 5'd1, 3'd1, 5'd4, 7'h1b}, rand64(), 0);  // slliw shamt 41
        run_single(r_type(7'h01, 3'd0, 7'h33), rand64(), rand64());      // mul
        run_single(r_type(7'h01, 3'd0, 7'h3b), rand64(), rand64());      // mulw
        run_single(r_type(7'h01, 3'd4, 7'h3b), rand64(), rand64());      // divw
        run_single(r_type(7'h10, 3'd0, 7'h33), rand64(), rand64());      // unknown funct7
        run_single({25'h0, 7'h7f}, rand64(), rand64());                  // unknown opcode
        end_test("illegal");

        // ------------------------------
        // divider
        // ------------------------------
        for (n = 0; n < 24; n = n + 1) begin
            a = rand64();
            b = rand64() >> ($random(seed) & 63);
            if (n < 4) begin
                b = 64'h0;  // by zero for div, divu, rem and remu
            end else if (n < 8) begin
                a = {1'b1, 63'h0};  // most negative over minus one
                b = {64{1'b1}};
            end else if (n == 8) begin
                a = {1'b1, 63'h0};
            end
            send(r_type(7'h01, 3'(4 + n % 4), 7'h33), a, b, 1'b1);
            wait_div();
        end
        end_test("divide");

        send(r_type(7'h01, 3'd4, 7'h33), rand64(), 64'd7, 1'b0);
        repeat (10) @(negedge clk);
        kill = 1'b1;
        @(negedge clk);
        kill = 1'b0;
        for (n = 0; n < 10 && busy; n = n + 1)
            @(negedge clk);
        if (busy) begin
            $display("timeout waiting for busy_o to fall after kill");
            err_cnt = err_cnt + 1;
            finish_run();
        end
        repeat (80) @(negedge clk);  // any valid_o here has nothing pending
        run_single(r_type(7'h00, 3'd0, 7'h33), rand64(), rand64());
        end_test("kill");

        send(r_type(7'h01, 3'd5, 7'h33), rand64(), 64'd13, 1'b1);
        repeat (5) @(negedge clk);
        if (!busy)
            report_error("busy_o low during divide");
        send(r_type(7'h00, 3'd4, 7'h33), rand64(), rand64(), 1'b0);
        wait_div();
        end_test("busy offer");

        for (n = 0; n < 20 && exp_q.size() != 0; n = n + 1)
            @(negedge clk);
        if (exp_q.size() != 0)
            report_error("results still pending at end of run");
        finish_run();
    end

endmodule

// ==== logic/int_unit_top.sv ====
/*
 * RV64I integer execution unit
 * Single-cycle ALU path and sequential 64-bit divider behind a
 * valid/busy handshake, with a registered write-back result
 */
`timescale 1ns/100ps
`include "int_unit_consts.svh"

module int_unit_top (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    kill_i,
    input  logic                    valid_i,
    input  logic [`PC_W-1:0]        pc_i,
    input  logic [31:0]             inst_i,
    input  int_unit_pkg::data_t     rs1_data_i,
    input  int_unit_pkg::data_t     rs2_data_i,
    output logic                    valid_o,
    output int_unit_pkg::data_t     result_o,
    output logic [`REG_ADDR_W-1:0]  rd_addr_o,
    output logic                    illegal_inst_o,
    output logic                    busy_o
);
    import int_unit_pkg::*;

    int_uop_t               uop;
    data_t                  alu_res, div_res, dvnd_q, dvsr_q;
    logic                   accept, div_start, div_signed_q, div_rem_q;
    logic                   cnt_clr, cnt_en, cnt_last;
    logic [`REG_ADDR_W-1:0] div_rd_q;

    div_ctrl_if ctl ();

    assign accept    = valid_i & ~busy_o;  // offers while busy are dropped
    assign div_start = accept & uop.is_div;

    int_decoder i_decoder (.inst_i(inst_i), .pc_i(pc_i), .rs1_data_i(rs1_data_i),
                           .rs2_data_i(rs2_data_i), .uop_o(uop));
    int_alu i_alu (.uop_i(uop), .result_o(alu_res));

    // ------------------------------
    // divider
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (div_start) begin
            dvnd_q       <= uop.opa;
            dvsr_q       <= uop.opb;
            div_signed_q <= uop.div_signed;
            div_rem_q    <= uop.div_rem;
            div_rd_q     <= uop.rd;
        end
    end

    div_ctrl i_div_ctrl (.clk_i(clk_i), .arst_n_i(arst_n_i), .start_i(div_start),
                         .kill_i(kill_i), .last_i(cnt_last), .cnt_clr_o(cnt_clr),
                         .cnt_en_o(cnt_en), .busy_o(busy_o), .ctl(ctl));
    div_step_counter #(.STEPS(`XLEN)) i_div_cnt (.clk_i(clk_i), .arst_n_i(arst_n_i),
                         .clr_i(cnt_clr), .en_i(cnt_en), .last_o(cnt_last));
    div_datapath i_div_dp (.clk_i(clk_i), .arst_n_i(arst_n_i), .ctl(ctl),
                         .signed_i(div_signed_q), .rem_i(div_rem_q), .dvnd_i(dvnd_q),
                         .dvsr_i(dvsr_q), .result_o(div_res));

    // ------------------------------
    // write-back register
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o        <= 1'b0;
            result_o       <= '0;
            rd_addr_o      <= '0;
            illegal_inst_o <= 1'b0;
        end else if (accept && !uop.is_div) begin  // alu and illegal, one cycle
            valid_o        <= 1'b1;
            result_o       <= alu_res;
            rd_addr_o      <= uop.rd;
            illegal_inst_o <= uop.illegal;
        end else if (ctl.finish && !kill_i) begin  // lands as busy_o drops
            valid_o        <= 1'b1;
            result_o       <= div_res;
            rd_addr_o      <= div_rd_q;
            illegal_inst_o <= 1'b0;
        end else begin
            valid_o        <= 1'b0;
        end
    end

endmodule

// ==== project.f ====
+incdir+common
common/int_unit_pkg.sv
common/div_ctrl_if.sv
alu/int_decoder.sv
alu/int_alu.sv
div/div_ctrl.sv
div/div_step_counter.sv
div/div_datapath.sv
logic/int_unit_top.sv
dv/int_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the integer unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module int_unit_tb \
    -f project.f -Mdir obj_dir -o int_unit_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/int_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    exit 0
fi
exit 1
